// File: rtl/cache_geometry_pkg.sv
package cache_geometry_pkg;

    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 64;

    localparam int NUM_WAYS  = 2;
    localparam int NUM_BANKS = 8;    // 64-bit banks per line
    localparam int NUM_SETS  = 512;

    // byte address split: tag | set | bank | byte
    localparam int TAG_LSB  = 15;
    localparam int SET_LSB  = 6;
    localparam int BANK_LSB = 3;

    typedef logic [ADDR_BITS-1:0] addr_t;

    typedef logic [ADDR_BITS-TAG_LSB-1:0] tag_t;     // addr[31:15]
    typedef logic [TAG_LSB-SET_LSB-1:0]   set_t;     // addr[14:6]
    typedef logic [SET_LSB-BANK_LSB-1:0]  bank_t;    // addr[5:3]

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
    typedef logic [NUM_WAYS-1:0]         way_mask_t;
    typedef logic [NUM_BANKS-1:0]        bank_mask_t;

    // data word, also used as the per-bit store mask
    typedef logic [WORD_BITS-1:0] word_t;

    // bank 0 sits in the low word
    typedef logic [NUM_BANKS*WORD_BITS-1:0] line_t;

endpackage

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int BUS_ADDR_BITS = 32;

    // memory side moves whole cache lines
    localparam int LINE_BYTES = 64;

    localparam int LINE_ADDR_BITS = BUS_ADDR_BITS - $clog2(LINE_BYTES);

    // byte address bits 31:6
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

endpackage

// File: rtl/cache_array_if.sv
interface tag_port_if;
    import cache_geometry_pkg::*;

    logic rd_en;
    set_t set;          // shared by read and write
    tag_t lookup_tag;   // sampled with rd_en
    logic wr_en;
    way_t wr_way;
    tag_t wr_tag;
    logic wr_dirty;

    // valid from the cycle after rd_en until the next rd_en
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_dirty;
    tag_t victim_tag;

    modport ctrl (
        output rd_en, set, lookup_tag, wr_en, wr_way, wr_tag, wr_dirty,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input  rd_en, set, lookup_tag, wr_en, wr_way, wr_tag, wr_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

interface data_port_if;
    import cache_geometry_pkg::*;

    logic       en;
    logic       we;
    set_t       set;
    way_t       way;
    bank_mask_t bank_en;
    line_t      wdata;
    line_t      wmask;
    line_t      rdata;   // one cycle after a read

    modport ctrl  (output en, we, set, way, bank_en, wdata, wmask, input  rdata);
    modport store (input  en, we, set, way, bank_en, wdata, wmask, output rdata);
endinterface

// File: rtl/tag_store.sv
module tag_store (
    input logic       clock,
    input logic       reset_n,
    tag_port_if.store tag
);
    import cache_geometry_pkg::*;

    tag_t      tag_mem   [NUM_SETS][NUM_WAYS];
    logic      dirty_mem [NUM_SETS][NUM_WAYS];
    way_mask_t valid_q   [NUM_SETS];

    tag_t       rd_tag_q [NUM_WAYS];   // read result of the last lookup
    way_mask_t  rd_dirty_q;
    way_mask_t  rd_valid_q;
    tag_t       cmp_tag_q;
    logic       rand_q;
    logic [7:0] lfsr_q;
    way_mask_t  hit_vec;
    way_t       victim;

    // valid bits, read capture and replacement LFSR
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
            rd_valid_q <= '0;
            rand_q     <= 1'b0;
            lfsr_q     <= 8'hff;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            if (tag.rd_en) begin
                rd_valid_q <= valid_q[tag.set];
                rand_q     <= lfsr_q[0];   // frozen with the lookup
            end
            if (tag.wr_en) begin
                valid_q[tag.set][tag.wr_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tag.rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_q[w]   <= tag_mem[tag.set][w];
                rd_dirty_q[w] <= dirty_mem[tag.set][w];
            end
            cmp_tag_q <= tag.lookup_tag;
        end
        if (tag.wr_en) begin
            tag_mem[tag.set][tag.wr_way]   <= tag.wr_tag;
            dirty_mem[tag.set][tag.wr_way] <= tag.wr_dirty;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag_q);
        end
    end

    // first free way, random pick when the set is full
    assign victim = !rd_valid_q[0] ? way_t'(0) : (!rd_valid_q[1] ? way_t'(1) : rand_q);

    assign tag.hit          = |hit_vec;
    assign tag.hit_way      = hit_vec[1];
    assign tag.victim_way   = victim;
    assign tag.victim_dirty = rd_valid_q[victim] && rd_dirty_q[victim];
    assign tag.victim_tag   = rd_tag_q[victim];

    // a line is never allocated twice in the same set
    hit_single_way: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(hit_vec));

endmodule

// File: rtl/data_store.sv
module data_store (
    input logic        clock,
    data_port_if.store data
);
    import cache_geometry_pkg::*;

    // one word per bank, way and set
    word_t bank_mem [NUM_WAYS][NUM_SETS][NUM_BANKS];

    always_ff @(posedge clock) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (data.en && data.bank_en[b]) begin
                if (data.we) begin
                    // keep the bits outside the mask
                    bank_mem[data.way][data.set][b] <=
                        (bank_mem[data.way][data.set][b]
                         & ~data.wmask[b*WORD_BITS +: WORD_BITS])
                        | (data.wdata[b*WORD_BITS +: WORD_BITS]
                           & data.wmask[b*WORD_BITS +: WORD_BITS]);
                end else begin
                    data.rdata[b*WORD_BITS +: WORD_BITS] <= bank_mem[data.way][data.set][b];
                end
            end
        end
    end

    // the controller never writes without selecting the array
    we_needs_en: assert property (@(posedge clock) data.we |-> data.en);

endmodule

// File: rtl/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_write,
    input  cache_geometry_pkg::addr_t  req_addr,
    input  cache_geometry_pkg::word_t  req_wdata,
    input  cache_geometry_pkg::word_t  req_wmask,
    output logic                       rsp_done,
    output cache_geometry_pkg::word_t  rsp_rdata,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output logic                       mem_req_write,
    output mem_bus_pkg::line_addr_t    mem_req_addr,
    output cache_geometry_pkg::line_t  mem_req_wdata,
    input  logic                       mem_rsp_valid,
    input  cache_geometry_pkg::line_t  mem_rsp_rdata,
    tag_port_if.ctrl                   tag,
    data_port_if.ctrl                  data
);
    import cache_geometry_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, HIT_READ, HIT_WRITE, EVICT_READ, WRITEBACK, REFILL, FILL
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic       req_write_q;
    addr_t      req_addr_q;
    word_t      req_wdata_q;
    word_t      req_wmask_q;
    line_t      fill_q;        // refilled line, waits one cycle for FILL
    line_t      merged_line;
    logic       sent_q;        // memory request transferred, response pending
    logic       mem_fire;
    logic       mem_rsp_ok;
    tag_t       req_tag;
    set_t       req_set;
    bank_t      req_bank;
    bank_mask_t bank_onehot;

    function automatic word_t pick_word(input line_t line, input bank_t bank);
        return line[bank*WORD_BITS +: WORD_BITS];
    endfunction

    assign req_tag     = req_addr_q[ADDR_BITS-1:TAG_LSB];
    assign req_set     = req_addr_q[TAG_LSB-1:SET_LSB];
    assign req_bank    = req_addr_q[SET_LSB-1:BANK_LSB];
    assign bank_onehot = bank_mask_t'(1) << req_bank;

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            req_write_q <= req_write;
            req_addr_q  <= req_addr;
            req_wdata_q <= req_wdata;
            req_wmask_q <= req_wmask;
        end
        if (state_q == REFILL && mem_rsp_ok) begin
            fill_q <= mem_rsp_rdata;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            sent_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (mem_rsp_ok) begin
                sent_q <= 1'b0;
            end else if (mem_fire) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (req_valid) state_d = LOOKUP;
            LOOKUP: begin
                if (tag.hit) begin
                    state_d = req_write_q ? HIT_WRITE : HIT_READ;
                end else begin
                    state_d = tag.victim_dirty ? EVICT_READ : REFILL;
                end
            end
            EVICT_READ: state_d = WRITEBACK;
            WRITEBACK:  if (mem_rsp_ok) state_d = REFILL;   // write acknowledged
            REFILL:     if (mem_rsp_ok) state_d = FILL;
            default:    state_d = IDLE;   // HIT_READ, HIT_WRITE, FILL
        endcase
    end

    // store word merged into the refilled line
    always_comb begin
        merged_line = fill_q;
        if (req_write_q) begin
            merged_line[req_bank*WORD_BITS +: WORD_BITS] =
                (pick_word(fill_q, req_bank) & ~req_wmask_q) | (req_wdata_q & req_wmask_q);
        end
    end

    assign req_ready = (state_q == IDLE);
    assign rsp_done  = state_q inside {HIT_READ, HIT_WRITE, FILL};

    always_comb begin
        rsp_rdata = '0;
        if (state_q == HIT_READ) begin
            rsp_rdata = pick_word(data.rdata, req_bank);
        end else if (state_q == FILL && !req_write_q) begin
            rsp_rdata = pick_word(fill_q, req_bank);
        end
    end

    assign mem_req_valid = (state_q == WRITEBACK || state_q == REFILL) && !sent_q;
    assign mem_req_write = (state_q == WRITEBACK);
    assign mem_req_addr  = mem_req_write ? {tag.victim_tag, req_set}
                                         : req_addr_q[ADDR_BITS-1:$clog2(LINE_BYTES)];
    assign mem_req_wdata = data.rdata;   // victim line from EVICT_READ
    assign mem_fire      = mem_req_valid && mem_req_ready;
    assign mem_rsp_ok    = mem_rsp_valid && (sent_q || mem_fire);

    // lookup uses the live address, everything later the registered one
    assign tag.rd_en      = req_valid && req_ready;
    assign tag.set        = (state_q == IDLE) ? req_addr[TAG_LSB-1:SET_LSB] : req_set;
    assign tag.lookup_tag = req_addr[ADDR_BITS-1:TAG_LSB];
    assign tag.wr_en      = (state_q == HIT_WRITE) || (state_q == FILL);
    assign tag.wr_way     = (state_q == HIT_WRITE) ? tag.hit_way : tag.victim_way;
    assign tag.wr_tag     = req_tag;
    assign tag.wr_dirty   = req_write_q;   // loads refill clean

    assign data.set = req_set;

    always_comb begin
        data.en      = 1'b0;
        data.we      = 1'b0;
        data.way     = tag.victim_way;
        data.bank_en = '0;
        data.wdata   = {NUM_BANKS{req_wdata_q}};
        data.wmask   = {NUM_BANKS{req_wmask_q}};
        case (state_q)
            LOOKUP: begin
                if (tag.hit && !req_write_q) begin   // early bank read for HIT_READ
                    data.en      = 1'b1;
                    data.way     = tag.hit_way;
                    data.bank_en = bank_onehot;
                end
            end
            EVICT_READ: begin
                data.en      = 1'b1;
                data.bank_en = '1;
            end
            HIT_WRITE: begin
                data.en      = 1'b1;
                data.we      = 1'b1;
                data.way     = tag.hit_way;
                data.bank_en = bank_onehot;
            end
            FILL: begin
                data.en      = 1'b1;
                data.we      = 1'b1;
                data.bank_en = '1;
                data.wdata   = merged_line;
                data.wmask   = '1;
            end
            default: ;
        endcase
    end

    mem_valid_held: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid);

    done_not_ready: assert property (@(posedge clock) disable iff (!reset_n)
        !(rsp_done && req_ready));

endmodule

// File: rtl/dcache_top.sv
module dcache_top (
    input  logic                       clock,
    input  logic                       reset_n,

    // core side
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_write,
    input  cache_geometry_pkg::addr_t  req_addr,
    input  cache_geometry_pkg::word_t  req_wdata,
    input  cache_geometry_pkg::word_t  req_wmask,
    output logic                       rsp_done,
    output cache_geometry_pkg::word_t  rsp_rdata,

    // memory side, one line per transfer
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output logic                       mem_req_write,
    output mem_bus_pkg::line_addr_t    mem_req_addr,
    output cache_geometry_pkg::line_t  mem_req_wdata,
    input  logic                       mem_rsp_valid,
    input  cache_geometry_pkg::line_t  mem_rsp_rdata
);

    tag_port_if  tag_if ();
    data_port_if data_if ();

    dcache_ctrl ctrl_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wmask     (req_wmask),
        .rsp_done      (rsp_done),
        .rsp_rdata     (rsp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .tag           (tag_if.ctrl),
        .data          (data_if.ctrl)
    );

    tag_store tag_store_i (
        .clock   (clock),
        .reset_n (reset_n),
        .tag     (tag_if.store)
    );

    data_store data_store_i (
        .clock (clock),
        .data  (data_if.store)
    );

endmodule

// File: verification/mem_model.sv
module mem_model #(
    parameter int                        SEED     = 1,
    parameter cache_geometry_pkg::word_t FILL_KEY = '0
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      mem_req_valid,
    output logic                      mem_req_ready,
    input  logic                      mem_req_write,
    input  mem_bus_pkg::line_addr_t   mem_req_addr,
    input  cache_geometry_pkg::line_t mem_req_wdata,
    output logic                      mem_rsp_valid,
    output cache_geometry_pkg::line_t mem_rsp_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    import cache_geometry_pkg::*;
    import mem_bus_pkg::*;

    line_t      lines [line_addr_t];   // lines written back so far
    int         seed = SEED;
    logic       busy;
    logic [2:0] stall;                 // cycles before ready rises
    logic [2:0] delay;                 // cycles before the response
    logic       pend_write;
    line_addr_t pend_addr;

    // untouched memory holds word address ^ key
    function automatic line_t fill_line(input line_addr_t la);
        line_t data;
        for (int b = 0; b < NUM_BANKS; b++) begin
            data[b*WORD_BITS +: WORD_BITS] = word_t'({la, bank_t'(b)}) ^ FILL_KEY;
        end
        return data;
    endfunction

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_rdata <= '0;
            busy          <= 1'b0;
            stall         <= 3'd0;
            delay         <= 3'd0;
            pend_write    <= 1'b0;
            pend_addr     <= '0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                mem_req_ready <= 1'b0;
                busy          <= 1'b1;
                delay         <= 3'($random(seed));
                stall         <= 3'($random(seed));   // for the next request
                pend_write    <= mem_req_write;
                pend_addr     <= mem_req_addr;
                if (mem_req_write) begin
                    lines[mem_req_addr] = mem_req_wdata;
                end
            end else if (busy) begin
                if (delay == 3'd0) begin
                    busy          <= 1'b0;
                    mem_rsp_valid <= 1'b1;
                    if (pend_write) begin
                        mem_rsp_rdata <= '0;   // write ack only
                    end else if (lines.exists(pend_addr)) begin
                        mem_rsp_rdata <= lines[pend_addr];
                    end else begin
                        mem_rsp_rdata <= fill_line(pend_addr);
                    end
                end else begin
                    delay <= delay - 3'd1;
                end
            end else if (mem_req_valid) begin
                if (stall == 3'd0) begin
                    mem_req_ready <= 1'b1;
                end else begin
                    stall <= stall - 3'd1;
                end
            end
        end
    end

endmodule

// File: verification/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cache_geometry_pkg::*;
    import mem_bus_pkg::*;

    typedef logic [ADDR_BITS-BANK_LSB-1:0] waddr_t;   // byte address bits 31:3

    localparam int    SEED         = 46826;
    localparam word_t FILL_KEY     = 64'h5a3c_96e1_0f87_d24b;
    localparam int    ACCEPT_LIMIT = 40;
    localparam int    DONE_LIMIT   = 120;
    localparam int    RANDOM_OPS   = 400;

    logic       clock, reset_n;
    logic       req_valid, req_ready, req_write, rsp_done;
    addr_t      req_addr;
    word_t      req_wdata, req_wmask, rsp_rdata;
    logic       mem_req_valid, mem_req_ready, mem_req_write, mem_rsp_valid;
    line_addr_t mem_req_addr;
    line_t      mem_req_wdata, mem_rsp_rdata;

    int    seed = SEED;
    int    errors, timeouts, loads, writebacks;
    addr_t cur_addr;              // request in flight
    word_t shadow [waddr_t];      // stored words only

    dcache_top dcache_top_i (.*);
    mem_model #(.SEED(SEED), .FILL_KEY(FILL_KEY)) mem_model_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic word_t pattern_word(input waddr_t w);
        return word_t'(w) ^ FILL_KEY;
    endfunction

    function automatic word_t shadow_word(input waddr_t w);
        return shadow.exists(w) ? shadow[w] : pattern_word(w);
    endfunction

    function automatic line_t shadow_line(input line_addr_t la);
        line_t data;
        for (int b = 0; b < NUM_BANKS; b++) begin
            data[b*WORD_BITS +: WORD_BITS] = shadow_word({la, bank_t'(b)});
        end
        return data;
    endfunction

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic end_run();
        $display("loads %0d, write-backs %0d, errors %0d, timeouts %0d",
                 loads, writebacks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: %s", what);
    endtask

    // one request from drive to rsp_done, checked against the shadow memory
    task automatic access(input logic write, input addr_t addr, input word_t wdata,
                          input word_t wmask, input logic expect_hit, output word_t rdata);
        int     waited;
        int     cycles;
        logic   accepted;
        waddr_t w;
        word_t  expected;

        rdata = '0;
        if (timeouts != 0) return;   // DUT already stuck, skip the rest
        w = addr[ADDR_BITS-1:BANK_LSB];
        cur_addr = addr;
        @(posedge clock);
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wmask <= wmask;
        waited = 0;
        do begin
            @(negedge clock);
            accepted = req_ready;
            waited++;
            @(posedge clock);
        end while (!accepted && waited < ACCEPT_LIMIT);
        if (!accepted) begin
            report_timeout($sformatf("request to %h was never accepted", addr));
            return;
        end
        req_valid <= 1'b0;   // the edge just passed took it
        if (write) shadow[w] = (shadow_word(w) & ~wmask) | (wdata & wmask);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!rsp_done && cycles < DONE_LIMIT);
        if (!rsp_done) begin
            report_timeout($sformatf("no rsp_done for request to %h", addr));
            return;
        end
        rdata = rsp_rdata;
        if (expect_hit) begin
            assert (cycles == 2)
                else log_error($sformatf("hit on %h took %0d cycles, expected 2", addr, cycles));
        end
        expected = write ? '0 : shadow_word(w);
        if (!write) loads++;
        assert (rsp_rdata == expected)
            else log_error($sformatf("rsp_rdata for %h is %h, expected %h",
                                     addr, rsp_rdata, expected));
    endtask

    // memory transfers, sampled mid-cycle
    always @(negedge clock) begin
        if (reset_n && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                writebacks++;
                assert (mem_req_wdata == shadow_line(mem_req_addr))
                    else log_error($sformatf("write-back of line %h is stale", mem_req_addr));
            end else begin
                assert (mem_req_addr == cur_addr[ADDR_BITS-1:SET_LSB])
                    else log_error($sformatf("refill of line %h, request is %h",
                                             mem_req_addr, cur_addr));
            end
        end
    end

    req_held_in_stall: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
            && $stable(mem_req_addr) && $stable(mem_req_wdata))
        else log_error("memory request changed while stalled");

    initial begin
        word_t got;
        addr_t addr;
        tag_t  t;
        set_t  s;

        errors     = 0;
        timeouts   = 0;
        loads      = 0;
        writebacks = 0;
        cur_addr   = '0;
        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wmask  = '0;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        assert (req_ready && !rsp_done && !mem_req_valid)
            else log_error("outputs not idle after reset");

        // cold miss, then hits on the filled line
        addr = 32'h0001_2340;
        access(1'b0, addr, '0, '0, 1'b0, got);
        assert (got == pattern_word(addr[ADDR_BITS-1:BANK_LSB]))
            else log_error("cold load does not return the memory pattern");
        access(1'b0, addr + 32'h8, '0, '0, 1'b1, got);
        access(1'b1, addr + 32'h10, rand_word(), rand_word(), 1'b1, got);
        access(1'b0, addr + 32'h10, '0, '0, 1'b1, got);

        // masked store miss, then a store hit on another bank
        for (int i = 0; i < 24; i++) begin
            addr = addr_t'($random(seed)) & ~addr_t'(7);
            access(1'b1, addr, rand_word(), rand_word(), 1'b0, got);
            access(1'b0, addr, '0, '0, 1'b1, got);
            addr = addr ^ 32'h18;
            access(1'b1, addr, rand_word(), rand_word(), 1'b1, got);
            access(1'b0, addr, '0, '0, 1'b1, got);
        end

        // three tags on four sets, forces dirty evictions
        for (int i = 0; i < RANDOM_OPS; i++) begin
            t    = tag_t'(32'h1234 + 32'h101 * ($unsigned($random(seed)) % 3));
            s    = set_t'(32'h0a5 * ($unsigned($random(seed)) % 4) + 32'h3);
            addr = {t, s, bank_t'($random(seed)), 3'b000};
            access(1'($random(seed)), addr, rand_word(), rand_word(), 1'b0, got);
        end

        if (writebacks == 0) begin
            errors++;
            $display("No dirty line was ever written back, eviction was not exercised");
        end
        end_run();
    end

endmodule

// File: dcache.f
rtl/cache_geometry_pkg.sv
rtl/mem_bus_pkg.sv
rtl/cache_array_if.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/mem_model.sv
verification/dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f dcache.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
